// File: Makefile
SIM    = verilator
VFLAGS = --binary --timing --assert
TOP    = tb_decode_stage
FLIST  = flist.f
OBJ    = obj_dir
LOG    = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove $(OBJ) and $(LOG)"
	@echo "  help   show this list"

test:
	$(SIM) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ)
	./$(OBJ)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@! grep -q "TESTS FAILED" $(LOG)
	@grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)

// File: bench/decode_model.svh
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// register-register forms first, illegal forms last
typedef enum int {
  K_ADD, K_SUB, K_SLT, K_SLTU, K_NOR, K_AND, K_OR, K_XOR,
  K_SLL, K_SRL, K_SRA, K_MUL, K_DIV,
  K_ADDI, K_SLTI, K_SLTUI, K_ANDI, K_ORI, K_XORI, K_SLLI, K_SRLI, K_SRAI,
  K_LU12I, K_PCADDU, K_LD, K_ST,
  K_BEQ, K_BNE, K_B, K_BL, K_JIRL,
  K_ILL_MAJ, K_ILL_3R
} kind_e;

localparam int NUM_KINDS = 33;

// r fills every operand and immediate field
function automatic logic [31:0] encode_instr(input kind_e k, input logic [31:0] r);
  logic [31:0] ins;
  case (k)
    K_ADD:    ins = {OP_MAJ_ALU, OP_MID_REG, OP_SUB_3R, OP_MIN_ADD, r[14:0]};
    K_SUB:    ins = {OP_MAJ_ALU, OP_MID_REG, OP_SUB_3R, OP_MIN_SUB, r[14:0]};
    K_SLT:    ins = {OP_MAJ_ALU, OP_MID_REG, OP_SUB_3R, OP_MIN_SLT, r[14:0]};
    K_SLTU:   ins = {OP_MAJ_ALU, OP_MID_REG, OP_SUB_3R, OP_MIN_SLTU, r[14:0]};
    K_NOR:    ins = {OP_MAJ_ALU, OP_MID_REG, OP_SUB_3R, OP_MIN_NOR, r[14:0]};
    K_AND:    ins = {OP_MAJ_ALU, OP_MID_REG, OP_SUB_3R, OP_MIN_AND, r[14:0]};
    K_OR:     ins = {OP_MAJ_ALU, OP_MID_REG, OP_SUB_3R, OP_MIN_OR, r[14:0]};
    K_XOR:    ins = {OP_MAJ_ALU, OP_MID_REG, OP_SUB_3R, OP_MIN_XOR, r[14:0]};
    K_SLL:    ins = {OP_MAJ_ALU, OP_MID_REG, OP_SUB_3R, OP_MIN_SLL, r[14:0]};
    K_SRL:    ins = {OP_MAJ_ALU, OP_MID_REG, OP_SUB_3R, OP_MIN_SRL, r[14:0]};
    K_SRA:    ins = {OP_MAJ_ALU, OP_MID_REG, OP_SUB_3R, OP_MIN_SRA, r[14:0]};
    K_MUL:    ins = {OP_MAJ_ALU, OP_MID_REG, OP_SUB_3R, OP_MIN_MUL, r[14:0]};
    K_DIV:    ins = {OP_MAJ_ALU, OP_MID_REG, OP_SUB_DIV, OP_MIN_DIV, r[14:0]};
    K_ADDI:   ins = {OP_MAJ_ALU, OP_MID_ADDI, r[21:0]};
    K_SLTI:   ins = {OP_MAJ_ALU, OP_MID_SLTI, r[21:0]};
    K_SLTUI:  ins = {OP_MAJ_ALU, OP_MID_SLTUI, r[21:0]};
    K_ANDI:   ins = {OP_MAJ_ALU, OP_MID_ANDI, r[21:0]};
    K_ORI:    ins = {OP_MAJ_ALU, OP_MID_ORI, r[21:0]};
    K_XORI:   ins = {OP_MAJ_ALU, OP_MID_XORI, r[21:0]};
    K_SLLI:   ins = {OP_MAJ_ALU, OP_MID_SHIFTI, OP_SUB_SHIFTI, OP_MIN_SLLI, r[14:0]};
    K_SRLI:   ins = {OP_MAJ_ALU, OP_MID_SHIFTI, OP_SUB_SHIFTI, OP_MIN_SRLI, r[14:0]};
    K_SRAI:   ins = {OP_MAJ_ALU, OP_MID_SHIFTI, OP_SUB_SHIFTI, OP_MIN_SRAI, r[14:0]};
    K_LU12I:  ins = {OP_MAJ_LU12I, 1'b0, r[24:0]};
    K_PCADDU: ins = {OP_MAJ_PCADDU, 1'b0, r[24:0]};
    K_LD:     ins = {OP_MAJ_MEM, OP_MID_LD_W, r[21:0]};
    K_ST:     ins = {OP_MAJ_MEM, OP_MID_ST_W, r[21:0]};
    K_BEQ:    ins = {OP_MAJ_BEQ, r[25:0]};
    K_BNE:    ins = {OP_MAJ_BNE, r[25:0]};
    K_B:      ins = {OP_MAJ_B, r[25:0]};
    K_BL:     ins = {OP_MAJ_BL, r[25:0]};
    K_JIRL:   ins = {OP_MAJ_JIRL, r[25:0]};
    // minor 0x1c..0x1f is unused in the 3R group
    K_ILL_3R: ins = {OP_MAJ_ALU, OP_MID_REG, OP_SUB_3R, 3'b111, r[16:0]};
    default:  ins = {2'b11, r[29:0]};
  endcase
  return ins;
endfunction

function automatic decoded_t decode_expected(input kind_e k, input logic [31:0] ins,
                                             input word_t pc);
  decoded_t d;
  logic     we;
  logic     reads_rd;
  d = '0;
  d.pc           = pc;
  d.illegal      = (k == K_ILL_MAJ) || (k == K_ILL_3R);
  d.is_mul       = (k == K_MUL);
  d.is_div       = (k == K_DIV);
  d.mem_we       = (k == K_ST);
  d.res_from_mem = (k == K_LD);
  d.is_ls        = (k == K_LD) || (k == K_ST);
  d.may_jump     = (k >= K_BEQ) && (k <= K_JIRL);
  d.src1_is_pc   = k inside {K_PCADDU, K_BL, K_JIRL};
  d.src2_is_4    = k inside {K_BL, K_JIRL};
  d.src2_is_imm  = (k >= K_ADDI) && (k <= K_ST);
  reads_rd       = k inside {K_ST, K_BEQ, K_BNE};
  d.use_rj       = !(k inside {K_LU12I, K_PCADDU, K_B, K_BL}) && !d.illegal;
  d.use_rkd      = (k <= K_DIV) || reads_rd;
  d.dest         = (k == K_BL) ? 5'd1 : ins[4:0];
  d.raddr1       = ins[9:5];
  d.raddr2       = reads_rd ? ins[4:0] : ins[14:10];
  we             = !(k inside {K_ST, K_BEQ, K_BNE, K_B}) && !d.illegal;
  d.gr_we        = we && (d.dest != 5'd0);
  case (k)
    K_SUB, K_BEQ, K_BNE:    d.alu_op = ALU_SUB;
    K_SLT, K_SLTI:          d.alu_op = ALU_SLT;
    K_SLTU, K_SLTUI:        d.alu_op = ALU_SLTU;
    K_AND, K_ANDI:          d.alu_op = ALU_AND;
    K_NOR:                  d.alu_op = ALU_NOR;
    K_OR, K_ORI:            d.alu_op = ALU_OR;
    K_XOR, K_XORI:          d.alu_op = ALU_XOR;
    K_SLL, K_SLLI:          d.alu_op = ALU_SLL;
    K_SRL, K_SRLI:          d.alu_op = ALU_SRL;
    K_SRA, K_SRAI:          d.alu_op = ALU_SRA;
    K_LU12I:                d.alu_op = ALU_LUI;
    default:                d.alu_op = ALU_ADD;
  endcase
  case (k)
    K_BEQ:   d.br_kind = BR_BEQ;
    K_BNE:   d.br_kind = BR_BNE;
    K_B:     d.br_kind = BR_B;
    K_BL:    d.br_kind = BR_BL;
    K_JIRL:  d.br_kind = BR_JIRL;
    default: d.br_kind = BR_NONE;
  endcase
  case (k)
    K_ADDI, K_SLTI, K_SLTUI, K_LD, K_ST: d.imm = {{20{ins[21]}}, ins[21:10]};
    K_ANDI, K_ORI, K_XORI:               d.imm = {20'b0, ins[21:10]};
    K_SLLI, K_SRLI, K_SRAI:              d.imm = {27'b0, ins[14:10]};
    K_LU12I, K_PCADDU:                   d.imm = {ins[24:5], 12'b0};
    K_BEQ, K_BNE, K_JIRL:                d.imm = {{14{ins[25]}}, ins[25:10], 2'b00};
    K_B, K_BL:                           d.imm = {{4{ins[9]}}, ins[9:0], ins[25:10], 2'b00};
    default:                             d.imm = '0;
  endcase
  return d;
endfunction

// slot 1 has to wait for the next cycle
function automatic logic pair_single(input decoded_t a, input decoded_t b);
  logic long0;
  logic hazard;
  long0  = a.is_mul || a.is_div;
  hazard = a.gr_we && (a.dest != 5'd0) &&
           (((a.dest == b.raddr1) && b.use_rj) || ((a.dest == b.raddr2) && b.use_rkd));
  return a.may_jump || a.is_ls || (b.may_jump && long0) || (b.is_ls && long0) ||
         (a.is_mul && b.is_mul) || (a.is_div && b.is_div) ||
         a.illegal || b.illegal || hazard;
endfunction

function automatic word_t forward_value(input reg_addr_t addr, input word_t rf,
                                        input fwd_t near, input fwd_t far);
  if (near.valid && near.gr_we && (near.dest == addr))
    return near.data;
  if (far.valid && far.gr_we && (far.dest == addr))
    return far.data;
  return rf;
endfunction

// register file contents, new salt every cycle
function automatic word_t rf_word(input reg_addr_t addr, input word_t salt);
  return salt ^ ({27'b0, addr} * 32'h9e37_79b1);
endfunction

`endif

// File: bench/tb_decode_stage.sv
`timescale 1ns/10ps

module tb_decode_stage;

  import decode_pkg::*;

  `include "decode_model.svh"

  localparam int NUM_CYCLES    = 4000;
  localparam int RESET_TIMEOUT = 20;

  logic              clk;
  logic              rst;
  fetch_slot_t [1:0] if_slot;
  logic [1:0]        if_valid;
  logic [1:0]        pop;
  reg_addr_t [3:0]   rf_raddr;
  word_t [3:0]       rf_rdata;
  fwd_t              fwd_near;
  fwd_t              fwd_far;
  issue_t [1:0]      exe_instr;
  logic [1:0]        exe_valid;
  logic              exe_ready;
  logic              flush;

  integer     seed;
  int         errors;
  int         checks;
  word_t      rf_salt;
  kind_e      slot_kind [2];
  issue_t     exp_instr [2];
  logic [1:0] exp_valid;
  logic       instr_known;

  decode_stage UUT (
    .clk       (clk),
    .rst       (rst),
    .if_slot   (if_slot),
    .if_valid  (if_valid),
    .pop       (pop),
    .rf_raddr  (rf_raddr),
    .rf_rdata  (rf_rdata),
    .fwd_near  (fwd_near),
    .fwd_far   (fwd_far),
    .exe_instr (exe_instr),
    .exe_valid (exe_valid),
    .exe_ready (exe_ready),
    .flush     (flush)
  );

  always #2 clk = ~clk;

  // combinational read ports
  always_comb
  begin
    for (int k = 0; k < 4; k++)
    begin
      rf_rdata[k] = rf_word(rf_raddr[k], rf_salt);
    end
  end

  task automatic check_field(input string name, input int slot, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp)
    else
    begin
      errors++;
      $display("CHECK FAILED at %0t: slot %0d %s is %h, expected %h",
               $time, slot, name, got, exp);
    end
  endtask

  task automatic make_fwd(output fwd_t f);
    logic [31:0] r;
    r       = $random(seed);
    f.valid = r[0];
    f.gr_we = r[1];
    // mostly low registers so that hits happen
    f.dest  = r[2] ? {2'b00, r[5:3]} : r[10:6];
    f.data  = $random(seed);
  endtask

  task automatic drive_random();
    kind_e       k;
    logic [31:0] ins;
    logic [31:0] r;
    logic        v0;
    fwd_t        fn;
    fwd_t        ff;
    for (int i = 0; i < 2; i++)
    begin
      k   = kind_e'($unsigned($random(seed)) % NUM_KINDS);
      ins = encode_instr(k, $random(seed));
      if ($random(seed) & 1)
        ins = ins & ~32'h0000_6318;
      if_slot[i].instr <= ins;
      if_slot[i].pc    <= $random(seed) & 32'hffff_fffc;
      slot_kind[i]     <= k;
    end
    v0 = ($random(seed) & 7) != 0;
    r  = $random(seed);
    if_valid  <= {v0 & r[0], v0};
    exe_ready <= ($random(seed) & 3) != 0;
    flush     <= ($random(seed) & 63) == 0;
    make_fwd(fn);
    make_fwd(ff);
    fwd_near  <= fn;
    fwd_far   <= ff;
    rf_salt   <= $random(seed);
  endtask

  // pop now, register contents after the coming edge
  task automatic predict_edge();
    decoded_t   d [2];
    logic       single;
    logic       issue1;
    logic [1:0] exp_pop;
    for (int i = 0; i < 2; i++)
    begin
      d[i] = decode_expected(slot_kind[i], if_slot[i].instr, if_slot[i].pc);
      check_field("rf_raddr rj", i, 32'(rf_raddr[2*i]), 32'(d[i].raddr1));
      check_field("rf_raddr rkd", i, 32'(rf_raddr[2*i+1]), 32'(d[i].raddr2));
    end
    single  = pair_single(d[0], d[1]);
    issue1  = if_valid[1] && !single;
    exp_pop = exe_ready ? {issue1, if_valid[0]} : 2'b00;
    check_field("pop", 0, {30'b0, pop}, {30'b0, exp_pop});
    if (exe_ready)
    begin
      for (int i = 0; i < 2; i++)
      begin
        exp_instr[i].dec       = d[i];
        exp_instr[i].rj_value  = forward_value(d[i].raddr1, rf_word(d[i].raddr1, rf_salt),
                                               fwd_near, fwd_far);
        exp_instr[i].rkd_value = forward_value(d[i].raddr2, rf_word(d[i].raddr2, rf_salt),
                                               fwd_near, fwd_far);
      end
      instr_known = 1'b1;
    end
    if (rst || flush)
      exp_valid = 2'b00;
    else if (exe_ready)
      exp_valid = {issue1, if_valid[0]};
  endtask

  task automatic compare_issue(input int i);
    issue_t g;
    issue_t e;
    g = exe_instr[i];
    e = exp_instr[i];
    check_field("pc", i, g.dec.pc, e.dec.pc);
    check_field("illegal", i, 32'(g.dec.illegal), 32'(e.dec.illegal));
    check_field("gr_we", i, 32'(g.dec.gr_we), 32'(e.dec.gr_we));
    check_field("mem_we", i, 32'(g.dec.mem_we), 32'(e.dec.mem_we));
    check_field("res_from_mem", i, 32'(g.dec.res_from_mem), 32'(e.dec.res_from_mem));
    check_field("is_mul", i, 32'(g.dec.is_mul), 32'(e.dec.is_mul));
    check_field("is_div", i, 32'(g.dec.is_div), 32'(e.dec.is_div));
    check_field("is_ls", i, 32'(g.dec.is_ls), 32'(e.dec.is_ls));
    check_field("may_jump", i, 32'(g.dec.may_jump), 32'(e.dec.may_jump));
    check_field("br_kind", i, 32'(g.dec.br_kind), 32'(e.dec.br_kind));
    check_field("dest", i, 32'(g.dec.dest), 32'(e.dec.dest));
    check_field("raddr1", i, 32'(g.dec.raddr1), 32'(e.dec.raddr1));
    check_field("raddr2", i, 32'(g.dec.raddr2), 32'(e.dec.raddr2));
    check_field("rj_value", i, g.rj_value, e.rj_value);
    check_field("rkd_value", i, g.rkd_value, e.rkd_value);
    check_field("alu_op", i, 32'(g.dec.alu_op), 32'(e.dec.alu_op));
    check_field("src1_is_pc", i, 32'(g.dec.src1_is_pc), 32'(e.dec.src1_is_pc));
    check_field("src2_is_imm", i, 32'(g.dec.src2_is_imm), 32'(e.dec.src2_is_imm));
    check_field("src2_is_4", i, 32'(g.dec.src2_is_4), 32'(e.dec.src2_is_4));
    check_field("use_rj", i, 32'(g.dec.use_rj), 32'(e.dec.use_rj));
    check_field("use_rkd", i, 32'(g.dec.use_rkd), 32'(e.dec.use_rkd));
    check_field("imm", i, g.dec.imm, e.dec.imm);
  endtask

  initial
  begin
    int waited;
    seed        = 32'h98fc6f03;
    errors      = 0;
    checks      = 0;
    clk         = 1'b0;
    rst         = 1'b1;
    if_valid    = 2'b00;
    exe_ready   = 1'b1;
    flush       = 1'b0;
    fwd_near    = '0;
    fwd_far     = '0;
    rf_salt     = '0;
    exp_valid   = 2'b00;
    instr_known = 1'b0;
    for (int i = 0; i < 2; i++)
    begin
      if_slot[i].pc    = '0;
      if_slot[i].instr = encode_instr(K_ILL_MAJ, '0);
      slot_kind[i]     = K_ILL_MAJ;
    end
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    waited = 0;
    @(negedge clk);
    while (rst !== 1'b0 && waited < RESET_TIMEOUT)
    begin
      @(negedge clk);
      waited++;
    end
    if (rst !== 1'b0)
    begin
      $display("reset was not released within %0d cycles", RESET_TIMEOUT);
      $display("TESTS FAILED");
      $finish;
    end
    else
    begin
      check_field("exe_valid after reset", 0, {30'b0, exe_valid}, 32'd0);
      predict_edge();
      for (int c = 0; c < NUM_CYCLES; c++)
      begin
        @(posedge clk);
        drive_random();
        @(negedge clk);
        check_field("exe_valid", 0, {30'b0, exe_valid}, {30'b0, exp_valid});
        if (instr_known)
        begin
          compare_issue(0);
          compare_issue(1);
        end
        predict_edge();
      end
      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0)
        $display("TESTS PASSED");
      else
        $display("TESTS FAILED");
      $finish;
    end
  end

endmodule

// File: flist.f
+incdir+bench
verilog/decode_pkg.sv
verilog/instr_decoder.sv
verilog/operand_bypass.sv
verilog/issue_ctrl.sv
verilog/decode_stage.sv
bench/tb_decode_stage.sv

// File: verilog/decode_pkg.sv
package decode_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;

  // major opcode, bits 31:26
  localparam logic [5:0] OP_MAJ_ALU    = 6'h00;
  localparam logic [5:0] OP_MAJ_LU12I  = 6'h05;
  localparam logic [5:0] OP_MAJ_PCADDU = 6'h07;
  localparam logic [5:0] OP_MAJ_MEM    = 6'h0a;
  localparam logic [5:0] OP_MAJ_JIRL   = 6'h13;
  localparam logic [5:0] OP_MAJ_B      = 6'h14;
  localparam logic [5:0] OP_MAJ_BL     = 6'h15;
  localparam logic [5:0] OP_MAJ_BEQ    = 6'h16;
  localparam logic [5:0] OP_MAJ_BNE    = 6'h17;

  // bits 25:22
  localparam logic [3:0] OP_MID_REG    = 4'h0;
  localparam logic [3:0] OP_MID_SHIFTI = 4'h1;
  localparam logic [3:0] OP_MID_LD_W   = 4'h2;
  localparam logic [3:0] OP_MID_ST_W   = 4'h6;
  localparam logic [3:0] OP_MID_SLTI   = 4'h8;
  localparam logic [3:0] OP_MID_SLTUI  = 4'h9;
  localparam logic [3:0] OP_MID_ADDI   = 4'ha;
  localparam logic [3:0] OP_MID_ANDI   = 4'hd;
  localparam logic [3:0] OP_MID_ORI    = 4'he;
  localparam logic [3:0] OP_MID_XORI   = 4'hf;

  // bits 21:20
  localparam logic [1:0] OP_SUB_SHIFTI = 2'h0;
  localparam logic [1:0] OP_SUB_3R     = 2'h1;
  localparam logic [1:0] OP_SUB_DIV    = 2'h2;

  // bits 19:15
  localparam logic [4:0] OP_MIN_ADD  = 5'h00;
  localparam logic [4:0] OP_MIN_SUB  = 5'h02;
  localparam logic [4:0] OP_MIN_SLT  = 5'h04;
  localparam logic [4:0] OP_MIN_SLTU = 5'h05;
  localparam logic [4:0] OP_MIN_NOR  = 5'h08;
  localparam logic [4:0] OP_MIN_AND  = 5'h09;
  localparam logic [4:0] OP_MIN_OR   = 5'h0a;
  localparam logic [4:0] OP_MIN_XOR  = 5'h0b;
  localparam logic [4:0] OP_MIN_SLL  = 5'h0e;
  localparam logic [4:0] OP_MIN_SRL  = 5'h0f;
  localparam logic [4:0] OP_MIN_SRA  = 5'h10;
  localparam logic [4:0] OP_MIN_MUL  = 5'h18;
  localparam logic [4:0] OP_MIN_DIV  = 5'h00;
  localparam logic [4:0] OP_MIN_SLLI = 5'h01;
  localparam logic [4:0] OP_MIN_SRLI = 5'h09;
  localparam logic [4:0] OP_MIN_SRAI = 5'h11;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLT,
    ALU_SLTU,
    ALU_AND,
    ALU_NOR,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_LUI
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_NONE,
    BR_BEQ,
    BR_BNE,
    BR_B,
    BR_BL,
    BR_JIRL
  } br_kind_e;

  typedef struct packed {
    word_t       pc;
    logic [31:0] instr;
  } fetch_slot_t;

  typedef struct packed {
    logic      valid;
    logic      gr_we;
    reg_addr_t dest;
    word_t     data;
  } fwd_t;

  typedef struct packed {
    alu_op_e   alu_op;
    br_kind_e  br_kind;
    word_t     pc;
    word_t     imm;
    logic      src1_is_pc;
    logic      src2_is_imm;
    logic      src2_is_4;
    logic      gr_we;
    logic      mem_we;
    logic      res_from_mem;
    logic      is_mul;
    logic      is_div;
    logic      is_ls;
    logic      may_jump;
    logic      use_rj;
    logic      use_rkd;
    logic      illegal;
    reg_addr_t dest;
    reg_addr_t raddr1;
    reg_addr_t raddr2;
  } decoded_t;

  typedef struct packed {
    decoded_t dec;
    word_t    rj_value;
    word_t    rkd_value;
  } issue_t;

endpackage

// File: verilog/decode_stage.sv
`timescale 1ns/10ps

module decode_stage (
  input  logic                          clk,
  input  logic                          rst,
  input  decode_pkg::fetch_slot_t [1:0] if_slot,
  input  logic [1:0]                    if_valid,
  output logic [1:0]                    pop,
  output decode_pkg::reg_addr_t [3:0]   rf_raddr,
  input  decode_pkg::word_t [3:0]       rf_rdata,
  input  decode_pkg::fwd_t              fwd_near,
  input  decode_pkg::fwd_t              fwd_far,
  output decode_pkg::issue_t [1:0]      exe_instr,
  output logic [1:0]                    exe_valid,
  input  logic                          exe_ready,
  input  logic                          flush
);

  import decode_pkg::*;

  decoded_t [1:0] dec;
  word_t [1:0]    rj_value;
  word_t [1:0]    rkd_value;

  // ports 2i and 2i+1 serve slot i
  for (genvar i = 0; i < 2; i++)
  begin : gen_slot
    instr_decoder u_decoder (
      .slot (if_slot[i]),
      .dec  (dec[i])
    );

    assign rf_raddr[2*i]   = dec[i].raddr1;
    assign rf_raddr[2*i+1] = dec[i].raddr2;

    operand_bypass u_bypass (
      .raddr1    (dec[i].raddr1),
      .raddr2    (dec[i].raddr2),
      .rdata1    (rf_rdata[2*i]),
      .rdata2    (rf_rdata[2*i+1]),
      .fwd_near  (fwd_near),
      .fwd_far   (fwd_far),
      .rj_value  (rj_value[i]),
      .rkd_value (rkd_value[i])
    );
  end

  issue_ctrl u_issue (
    .clk       (clk),
    .rst       (rst),
    .dec       (dec),
    .rj_value  (rj_value),
    .rkd_value (rkd_value),
    .if_valid  (if_valid),
    .pop       (pop),
    .exe_ready (exe_ready),
    .flush     (flush),
    .exe_instr (exe_instr),
    .exe_valid (exe_valid)
  );

endmodule

// File: verilog/instr_decoder.sv
`timescale 1ns/10ps

module instr_decoder (
  input  decode_pkg::fetch_slot_t slot,
  output decode_pkg::decoded_t    dec
);

  import decode_pkg::*;

  logic [31:0] ins;
  logic [5:0]  op_31_26;
  logic [3:0]  op_25_22;
  logic [1:0]  op_21_20;
  logic [4:0]  op_19_15;
  reg_addr_t   rd;
  reg_addr_t   rj;
  reg_addr_t   rk;
  reg_addr_t   dest;
  logic [11:0] i12;
  logic [15:0] i16;
  logic [19:0] i20;
  logic [25:0] i26;

  logic grp_alu;
  logic grp_3r;
  logic grp_div;
  logic grp_shifti;
  logic grp_mem;

  logic inst_add_w, inst_sub_w, inst_slt, inst_sltu;
  logic inst_nor, inst_and, inst_or, inst_xor;
  logic inst_addi_w, inst_slti, inst_sltui, inst_andi, inst_ori, inst_xori;
  logic inst_slli_w, inst_srli_w, inst_srai_w;
  logic inst_sll_w, inst_srl_w, inst_sra_w;
  logic inst_lu12i_w, inst_pcaddu12i, inst_ld_w, inst_st_w;
  logic inst_beq, inst_bne, inst_b, inst_bl, inst_jirl;
  logic inst_mul_w, inst_div_w;

  logic    kept;
  logic    reads_rd;
  logic    src2_imm;
  alu_op_e alu_op;
  word_t   imm;

  assign ins      = slot.instr;
  assign op_31_26 = ins[31:26];
  assign op_25_22 = ins[25:22];
  assign op_21_20 = ins[21:20];
  assign op_19_15 = ins[19:15];
  assign rd       = ins[4:0];
  assign rj       = ins[9:5];
  assign rk       = ins[14:10];
  assign i12      = ins[21:10];
  assign i16      = ins[25:10];
  assign i20      = ins[24:5];
  assign i26      = {ins[9:0], ins[25:10]};

  assign grp_alu    = (op_31_26 == OP_MAJ_ALU);
  assign grp_3r     = grp_alu && (op_25_22 == OP_MID_REG) && (op_21_20 == OP_SUB_3R);
  assign grp_div    = grp_alu && (op_25_22 == OP_MID_REG) && (op_21_20 == OP_SUB_DIV);
  assign grp_shifti = grp_alu && (op_25_22 == OP_MID_SHIFTI) && (op_21_20 == OP_SUB_SHIFTI);
  assign grp_mem    = (op_31_26 == OP_MAJ_MEM);

  assign inst_add_w  = grp_3r && (op_19_15 == OP_MIN_ADD);
  assign inst_sub_w  = grp_3r && (op_19_15 == OP_MIN_SUB);
  assign inst_slt    = grp_3r && (op_19_15 == OP_MIN_SLT);
  assign inst_sltu   = grp_3r && (op_19_15 == OP_MIN_SLTU);
  assign inst_nor    = grp_3r && (op_19_15 == OP_MIN_NOR);
  assign inst_and    = grp_3r && (op_19_15 == OP_MIN_AND);
  assign inst_or     = grp_3r && (op_19_15 == OP_MIN_OR);
  assign inst_xor    = grp_3r && (op_19_15 == OP_MIN_XOR);
  assign inst_sll_w  = grp_3r && (op_19_15 == OP_MIN_SLL);
  assign inst_srl_w  = grp_3r && (op_19_15 == OP_MIN_SRL);
  assign inst_sra_w  = grp_3r && (op_19_15 == OP_MIN_SRA);
  assign inst_mul_w  = grp_3r && (op_19_15 == OP_MIN_MUL);
  assign inst_div_w  = grp_div && (op_19_15 == OP_MIN_DIV);
  assign inst_slli_w = grp_shifti && (op_19_15 == OP_MIN_SLLI);
  assign inst_srli_w = grp_shifti && (op_19_15 == OP_MIN_SRLI);
  assign inst_srai_w = grp_shifti && (op_19_15 == OP_MIN_SRAI);

  assign inst_slti   = grp_alu && (op_25_22 == OP_MID_SLTI);
  assign inst_sltui  = grp_alu && (op_25_22 == OP_MID_SLTUI);
  assign inst_addi_w = grp_alu && (op_25_22 == OP_MID_ADDI);
  assign inst_andi   = grp_alu && (op_25_22 == OP_MID_ANDI);
  assign inst_ori    = grp_alu && (op_25_22 == OP_MID_ORI);
  assign inst_xori   = grp_alu && (op_25_22 == OP_MID_XORI);
  assign inst_ld_w   = grp_mem && (op_25_22 == OP_MID_LD_W);
  assign inst_st_w   = grp_mem && (op_25_22 == OP_MID_ST_W);

  // 1RI20 forms need bit 25 clear
  assign inst_lu12i_w   = (op_31_26 == OP_MAJ_LU12I) && !ins[25];
  assign inst_pcaddu12i = (op_31_26 == OP_MAJ_PCADDU) && !ins[25];
  assign inst_jirl      = (op_31_26 == OP_MAJ_JIRL);
  assign inst_b         = (op_31_26 == OP_MAJ_B);
  assign inst_bl        = (op_31_26 == OP_MAJ_BL);
  assign inst_beq       = (op_31_26 == OP_MAJ_BEQ);
  assign inst_bne       = (op_31_26 == OP_MAJ_BNE);

  assign kept = inst_add_w | inst_sub_w | inst_slt | inst_sltu | inst_nor | inst_and |
                inst_or | inst_xor | inst_addi_w | inst_slti | inst_sltui | inst_andi |
                inst_ori | inst_xori | inst_slli_w | inst_srli_w | inst_srai_w |
                inst_sll_w | inst_srl_w | inst_sra_w | inst_lu12i_w | inst_pcaddu12i |
                inst_ld_w | inst_st_w | inst_beq | inst_bne | inst_b | inst_bl |
                inst_jirl | inst_mul_w | inst_div_w;

  assign reads_rd = inst_beq | inst_bne | inst_st_w;
  assign dest     = inst_bl ? 5'd1 : rd;
  assign src2_imm = inst_slli_w | inst_srli_w | inst_srai_w | inst_addi_w | inst_slti |
                    inst_sltui | inst_andi | inst_ori | inst_xori | inst_ld_w |
                    inst_st_w | inst_lu12i_w | inst_pcaddu12i;

  always_comb
  begin
    if (inst_sub_w || inst_beq || inst_bne)
      alu_op = ALU_SUB;
    else if (inst_slt || inst_slti)
      alu_op = ALU_SLT;
    else if (inst_sltu || inst_sltui)
      alu_op = ALU_SLTU;
    else if (inst_and || inst_andi)
      alu_op = ALU_AND;
    else if (inst_nor)
      alu_op = ALU_NOR;
    else if (inst_or || inst_ori)
      alu_op = ALU_OR;
    else if (inst_xor || inst_xori)
      alu_op = ALU_XOR;
    else if (inst_sll_w || inst_slli_w)
      alu_op = ALU_SLL;
    else if (inst_srl_w || inst_srli_w)
      alu_op = ALU_SRL;
    else if (inst_sra_w || inst_srai_w)
      alu_op = ALU_SRA;
    else if (inst_lu12i_w)
      alu_op = ALU_LUI;
    else
      alu_op = ALU_ADD;
  end

  // immediate by encoding class, branch offsets are word scaled
  always_comb
  begin
    if (inst_lu12i_w || inst_pcaddu12i)
      imm = {i20, 12'b0};
    else if (inst_slli_w || inst_srli_w || inst_srai_w)
      imm = {27'b0, rk};
    else if (inst_b || inst_bl)
      imm = {{4{i26[25]}}, i26, 2'b00};
    else if (inst_jirl || inst_beq || inst_bne)
      imm = {{14{i16[15]}}, i16, 2'b00};
    else if (inst_andi || inst_ori || inst_xori)
      imm = {20'b0, i12};
    else if (inst_addi_w || inst_slti || inst_sltui || inst_ld_w || inst_st_w)
      imm = {{20{i12[11]}}, i12};
    else
      imm = '0;
  end

  always_comb
  begin
    dec.alu_op       = alu_op;
    dec.br_kind      = inst_beq  ? BR_BEQ  :
                       inst_bne  ? BR_BNE  :
                       inst_b    ? BR_B    :
                       inst_bl   ? BR_BL   :
                       inst_jirl ? BR_JIRL : BR_NONE;
    dec.pc           = slot.pc;
    dec.imm          = imm;
    dec.src1_is_pc   = inst_jirl | inst_bl | inst_pcaddu12i;
    dec.src2_is_imm  = src2_imm;
    dec.src2_is_4    = inst_jirl | inst_bl;
    dec.gr_we        = kept & ~(inst_st_w | inst_beq | inst_bne | inst_b) & (|dest);
    dec.mem_we       = inst_st_w;
    dec.res_from_mem = inst_ld_w;
    dec.is_mul       = inst_mul_w;
    dec.is_div       = inst_div_w;
    dec.is_ls        = inst_ld_w | inst_st_w;
    dec.may_jump     = inst_beq | inst_bne | inst_b | inst_bl | inst_jirl;
    dec.use_rj       = kept & ~(inst_lu12i_w | inst_pcaddu12i | inst_b | inst_bl);
    dec.use_rkd      = kept & (grp_3r | grp_div | reads_rd);
    dec.illegal      = ~kept;
    dec.dest         = dest;
    dec.raddr1       = rj;
    dec.raddr2       = reads_rd ? rd : rk;
  end

endmodule

// File: verilog/issue_ctrl.sv
`timescale 1ns/10ps

module issue_ctrl (
  input  logic                       clk,
  input  logic                       rst,
  input  decode_pkg::decoded_t [1:0] dec,
  input  decode_pkg::word_t [1:0]    rj_value,
  input  decode_pkg::word_t [1:0]    rkd_value,
  input  logic [1:0]                 if_valid,
  output logic [1:0]                 pop,
  input  logic                       exe_ready,
  input  logic                       flush,
  output decode_pkg::issue_t [1:0]   exe_instr,
  output logic [1:0]                 exe_valid
);

  import decode_pkg::*;

  logic         slot0_long;
  logic         slot0_writes;
  logic         raw_hazard;
  logic         single;
  logic         issue1;
  issue_t [1:0] issue_next;

  // slot 0 occupies the mul or div unit
  assign slot0_long   = dec[0].is_mul | dec[0].is_div;
  assign slot0_writes = dec[0].gr_we & (|dec[0].dest);

  // slot 1 reads what slot 0 is about to write
  assign raw_hazard = slot0_writes &
                      (((dec[0].dest == dec[1].raddr1) & dec[1].use_rj) |
                       ((dec[0].dest == dec[1].raddr2) & dec[1].use_rkd));

  assign single = dec[0].may_jump |
                  dec[0].is_ls |
                  (dec[1].may_jump & slot0_long) |
                  (dec[1].is_ls & slot0_long) |
                  (dec[0].is_mul & dec[1].is_mul) |
                  (dec[0].is_div & dec[1].is_div) |
                  dec[0].illegal |
                  dec[1].illegal |
                  raw_hazard;

  assign issue1 = if_valid[1] & ~single;

  assign pop[0] = if_valid[0] & exe_ready;
  assign pop[1] = issue1 & exe_ready;

  always_comb
  begin
    for (int i = 0; i < 2; i++)
    begin
      issue_next[i].dec       = dec[i];
      issue_next[i].rj_value  = rj_value[i];
      issue_next[i].rkd_value = rkd_value[i];
    end
  end

  always_ff @(posedge clk)
  begin
    if (exe_ready)
    begin
      exe_instr <= issue_next;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst || flush)
    begin
      exe_valid <= 2'b00;
    end
    else if (exe_ready)
    begin
      exe_valid <= {issue1, if_valid[0]};
    end
  end

  a_valid_cleared: assert property (@(posedge clk) (rst || flush) |=> (exe_valid == 2'b00))
    else $error("exe_valid set in the cycle after reset or flush");

  // fetch shifts by the pop count
  a_pop_in_order: assert property (@(posedge clk) disable iff (rst)
    pop[1] |-> pop[0])
    else $error("slot 1 popped without slot 0");

endmodule

// File: verilog/operand_bypass.sv
`timescale 1ns/10ps

module operand_bypass (
  input  decode_pkg::reg_addr_t raddr1,
  input  decode_pkg::reg_addr_t raddr2,
  input  decode_pkg::word_t     rdata1,
  input  decode_pkg::word_t     rdata2,
  input  decode_pkg::fwd_t      fwd_near,
  input  decode_pkg::fwd_t      fwd_far,
  output decode_pkg::word_t     rj_value,
  output decode_pkg::word_t     rkd_value
);

  import decode_pkg::*;

  // youngest result first, r0 goes through like any other register
  function automatic word_t pick(input reg_addr_t addr, input word_t rf_data,
                                 input fwd_t near, input fwd_t far);
    word_t value;
    if (near.valid && near.gr_we && (near.dest == addr))
    begin
      value = near.data;
    end
    else if (far.valid && far.gr_we && (far.dest == addr))
    begin
      value = far.data;
    end
    else
    begin
      value = rf_data;
    end
    return value;
  endfunction

  assign rj_value  = pick(raddr1, rdata1, fwd_near, fwd_far);
  assign rkd_value = pick(raddr2, rdata2, fwd_near, fwd_far);

endmodule
